// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= computeCoreTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps -j 0
SIMFLAGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) $(SIMFLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG); then \
		echo "Test run reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== src.f ====
verilog/corePkg.sv
verilog/instrDecoder.sv
verilog/registerFile.sv
verilog/hazardUnit.sv
verilog/executeUnit.sv
verilog/computeCore.sv
tb/computeCore_asserts.sv
tb/computeCoreTb.sv

// ==== tb/computeCoreTb.sv ====
// Program is 246 straight-line instructions; every load and store uses x0 as base below 1 KiB
`timescale 1ns/1ps

module computeCoreTb;
    import corePkg::*;

    logic      clk = 1'b0;
    logic      rstN;
    logic [31:0] pc;
    instrWord  instr;
    memRequest dmem;
    logic [31:0] memReadData;

    logic [31:0] imem [1024];
    logic [31:0] dataMem [256];
    logic [31:0] expAdr [$];
    logic [31:0] expData [$];
    logic [31:0] wantAdr;
    logic [31:0] wantData;
    logic [31:0] lfsrState;
    int programLen;
    int firstMemIdx;
    int sinceReset = 0;
    int cycleLimit = 1000;
    int valueErrors = 0;
    int extraStores = 0;

    computeCore u_computeCore (
        .clk         (clk),
        .rstN        (rstN),
        .pc          (pc),
        .instr       (instr),
        .dmem        (dmem),
        .memReadData (memReadData)
    );

    always #4 clk = ~clk;

    assign instr       = imem[pc[11:2]];
    // Read data only while the port is enabled
    assign memReadData = dmem.en ? dataMem[dmem.adr[9:2]] : 32'hdead_beef;

    function automatic logic [31:0] fillWord(logic [7:0] idx);
        return {idx, ~idx, idx ^ 8'ha5, idx ^ 8'h3c};
    endfunction

    // Galois LFSR, one step per bit
    function automatic logic [31:0] randomBits(int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value     = {value[30:0], lfsrState[0]};
            lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h80200003 : 32'h0);
        end
        return value;
    endfunction

    task automatic buildProgram();
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  prevRd;
        logic [11:0] imm;
        logic        alt;
        logic        forceDep;
        int          n;
        n           = 0;
        prevRd      = 5'd1;
        forceDep    = 1'b0;
        firstMemIdx = -1;
        for (int i = 0; i < 1024; i++)
            imem[10'(i)] = '0;
        // Seed x1 to x15 with LUI then ADDI
        for (int r = 1; r < 16; r++) begin
            imem[10'(n)]     = {20'(randomBits(20)), 5'(r), opLui};
            imem[10'(n + 1)] = {12'(randomBits(12)), 5'(r), 3'b000, 5'(r), opOpImm};
            n += 2;
        end
        for (int k = 0; k < 200; k++) begin
            kind = 3'(randomBits(3));
            f3   = 3'(randomBits(3));
            rd   = 5'(randomBits(4));
            rs2  = 5'(randomBits(4));
            alt  = 1'(randomBits(1));
            imm  = 12'(randomBits(12));
            // A load is always followed by a consumer of its result
            rs1 = (forceDep || 1'(randomBits(1))) ? prevRd : 5'(randomBits(4));
            if (forceDep && (kind == 3'd5 || kind == 3'd6))
                kind = 3'd4;
            if ((kind == 3'd6 || kind == 3'd7) && firstMemIdx < 0)
                firstMemIdx = n;
            case (kind)
                3'd4: begin
                    if (f3 == 3'b001 || f3 == 3'b101)
                        imm[11:5] = {1'b0, alt && f3[2], 5'b0};
                    imem[10'(n)] = {imm, rs1, f3, rd, opOpImm};
                end
                3'd5: imem[10'(n)] = {imm, rs1, f3, rd, opLui};
                3'd6: imem[10'(n)] = {4'b0001, imm[5:0], 2'b00, 5'd0, 3'b010, rd, opLoad};
                // Stored register is the dependent one
                3'd7: imem[10'(n)] = {4'b0001, imm[5:3], rs1, 5'd0, 3'b010, imm[2:0], 2'b00, opStore};
                default: begin
                    imem[10'(n)] = {1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'b0,
                                    rs2, rs1, f3, rd, opOp};
                end
            endcase
            forceDep = (kind == 3'd6);
            if (kind != 3'd7)
                prevRd = rd;
            n++;
        end
        if (firstMemIdx < 0)
            firstMemIdx = n;
        // Each register to its own word address, x0 included
        for (int r = 0; r < 16; r++) begin
            imm          = 12'(4 * r);
            imem[10'(n)] = {imm[11:5], 5'(r), 5'd0, 3'b010, imm[4:0], opStore};
            n++;
        end
        programLen = n;
    endtask

    function automatic logic [31:0] aluModel(logic [2:0] f3, logic alt,
                                             logic [31:0] a, logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << b[4:0];
            3'b010: r = {31'b0, $signed(a) < $signed(b)};
            3'b011: r = {31'b0, a < b};
            3'b100: r = a ^ b;
            3'b101: begin
                if (alt)
                    r = $signed(a) >>> b[4:0];
                else
                    r = a >> b[4:0];
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // Architectural model, records every store in program order
    function automatic void runReference();
        logic [31:0] regs [32];
        logic [31:0] mem [256];
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sum;
        logic [31:0] adr;
        logic [31:0] result;
        logic        wr;
        for (int i = 0; i < 32; i++)
            regs[5'(i)] = '0;
        for (int i = 0; i < 256; i++)
            mem[8'(i)] = fillWord(8'(i));
        for (int p = 0; p < programLen; p++) begin
            w      = imem[10'(p)];
            a      = regs[w[19:15]];
            b      = (w[6:0] == opOp) ? regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
            sum    = a + b;
            adr    = a + {{20{w[31]}}, w[31:25], w[11:7]};
            wr     = 1'b1;
            result = '0;
            case (w[6:0])
                opOp:    result = aluModel(w[14:12], w[30], a, b);
                opOpImm: result = aluModel(w[14:12], w[30] && w[14:12] == 3'b101, a, b);
                opLui:   result = {w[31:12], 12'b0};
                opLoad:  result = mem[sum[9:2]];
                opStore: begin
                    mem[adr[9:2]] = regs[w[24:20]];
                    expAdr.push_back(adr);
                    expData.push_back(regs[w[24:20]]);
                    wr = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            if (wr && w[11:7] != 5'd0)
                regs[w[11:7]] = result;
        end
    endfunction

    task automatic printErrorCounts();
        $display("Errors: %0d wrong values, %0d missing stores, %0d extra stores, %0d asserts",
                 valueErrors, expAdr.size(), extraStores,
                 u_computeCore.u_computeCoreAsserts.failCount);
    endtask

    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 256; i++)
                dataMem[8'(i)] <= fillWord(8'(i));
        end else if (dmem.en && dmem.writeEn) begin
            dataMem[dmem.adr[9:2]] <= dmem.writeData;
        end
    end

    always @(posedge clk) begin
        if (rstN)
            sinceReset <= sinceReset + 1;
        if (sinceReset > cycleLimit) begin
            $display("Timeout after %0d cycles with %0d stores never seen", sinceReset,
                     expAdr.size());
            printErrorCounts();
            $display("Simulation failed");
            $finish;
        end
    end

    // Outputs settle between edges
    always @(negedge clk) begin
        if (rstN && sinceReset == 0 && pc != '0) begin
            valueErrors++;
            $display("Fail at %0t: first pc after reset is %h", $time, pc);
        end
        if (dmem.en && (!rstN || sinceReset < firstMemIdx + 3)) begin
            valueErrors++;
            $display("Fail at %0t: data access before any memory instruction", $time);
        end
        if (rstN && dmem.en && dmem.writeEn) begin
            if (expAdr.size() == 0) begin
                extraStores++;
                $display("Extra store at %0t to address %h after the last one", $time, dmem.adr);
            end else begin
                wantAdr  = expAdr.pop_front();
                wantData = expData.pop_front();
                if (dmem.adr != wantAdr || dmem.writeData != wantData) begin
                    valueErrors++;
                    $display("Fail at %0t: store %h to %h, expected %h to %h", $time,
                             dmem.writeData, dmem.adr, wantData, wantAdr);
                end
            end
        end
    end

    initial begin
        rstN      = 1'b0;
        lfsrState = 32'h6f95;
        buildProgram();
        runReference();
        cycleLimit = 2 * programLen + 50;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        while (expAdr.size() != 0)
            @(posedge clk);
        // Room for a stray store to show up
        repeat (6) @(posedge clk);
        printErrorCounts();
        if (valueErrors + extraStores + u_computeCore.u_computeCoreAsserts.failCount == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== tb/computeCore_asserts.sv ====
// Sampled on the core clock; x0 is checked on the C-stage operands after forwarding
`timescale 1ns/1ps

module computeCore_asserts (
    input logic                            clk,
    input logic                            rstN,
    input logic                            dmemEn,
    input logic                            stall,
    input logic [corePkg::xlen-1:0]        pc,
    input logic [corePkg::regAdrWidth-1:0] rs1Adr,
    input logic [corePkg::regAdrWidth-1:0] rs2Adr,
    input logic [corePkg::xlen-1:0]        rs1Data,
    input corePkg::fwdSrc                  fwdA,
    input logic [corePkg::xlen-1:0]        storeData
);
    import corePkg::*;

    int failCount = 0;

    // Pipeline registers come out of reset empty
    quietAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !dmemEn)
        else begin
            failCount++;
            $error("Data port enabled in the first cycle after reset");
        end

    pcHeldOnStall: assert property (@(posedge clk) disable iff (!rstN) stall |=> $stable(pc))
        else begin
            failCount++;
            $error("pc moved during a load-use stall");
        end

    // A write to x0 in M or W must never reach the operands
    zeroReadA: assert property (@(posedge clk) disable iff (!rstN)
                                (rs1Adr == '0) |-> (fwdA == noForward && rs1Data == '0))
        else begin
            failCount++;
            $error("Register 0 operand nonzero on rs1");
        end

    zeroReadB: assert property (@(posedge clk) disable iff (!rstN)
                                (rs2Adr == '0) |-> (storeData == '0))
        else begin
            failCount++;
            $error("Register 0 operand nonzero on rs2");
        end

endmodule

bind computeCore computeCore_asserts u_computeCoreAsserts (
    .clk       (clk),
    .rstN      (rstN),
    .dmemEn    (dmem.en),
    .stall     (stall),
    .pc        (pc),
    .rs1Adr    (rcReg.rs1Adr),
    .rs2Adr    (rcReg.rs2Adr),
    .rs1Data   (rcReg.rs1Data),
    .fwdA      (fwdA),
    .storeData (storeDataC)
);

// ==== verilog/computeCore.sv ====
// Straight-line fetch only (pc + 4); instr and memReadData must answer in the same cycle
`timescale 1ns/1ps

module computeCore (
    input  logic                     clk,
    input  logic                     rstN,
    output logic [corePkg::xlen-1:0] pc,
    input  corePkg::instrWord        instr,
    output corePkg::memRequest       dmem,
    input  logic [corePkg::xlen-1:0] memReadData
);
    import corePkg::*;

    typedef struct packed {
        instrWord instr;
    } irBundle;

    typedef struct packed {
        ctrlBundle              ctrl;
        logic [xlen-1:0]        rs1Data;
        logic [xlen-1:0]        rs2Data;
        logic [xlen-1:0]        imm;
        logic [regAdrWidth-1:0] rs1Adr;
        logic [regAdrWidth-1:0] rs2Adr;
    } rcBundle;

    typedef struct packed {
        ctrlBundle       ctrl;
        logic [xlen-1:0] computeResult;
        logic [xlen-1:0] storeData;
    } cmBundle;

    typedef struct packed {
        ctrlBundle       ctrl;
        logic [xlen-1:0] computeResult;
        logic [xlen-1:0] memReadData;
    } mwBundle;

    irBundle irReg;
    rcBundle rcReg;
    rcBundle rcNext;
    cmBundle cmReg;
    mwBundle mwReg;

    ctrlBundle       ctrlR;
    logic [xlen-1:0] immR;
    logic [xlen-1:0] rs1DataR;
    logic [xlen-1:0] rs2DataR;

    fwdSrc           fwdA;
    fwdSrc           fwdB;
    logic            stall;
    logic [xlen-1:0] computeResultC;
    logic [xlen-1:0] storeDataC;
    logic [xlen-1:0] resultW;

    // I stage
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc    <= '0;
            irReg <= '0;
        end else if (!stall) begin
            pc          <= pc + xlen'(4);
            irReg.instr <= instr;
        end
    end

    // R stage
    instrDecoder u_instrDecoder (
        .instr (irReg.instr),
        .ctrl  (ctrlR),
        .imm   (immR)
    );

    registerFile u_registerFile (
        .clk     (clk),
        .rstN    (rstN),
        .writeEn (mwReg.ctrl.regWrite),
        .rs1Adr  (irReg.instr.rFormat.rs1),
        .rs2Adr  (irReg.instr.rFormat.rs2),
        .rdAdr   (mwReg.ctrl.rd),
        .rdData  (resultW),
        .rs1Data (rs1DataR),
        .rs2Data (rs2DataR)
    );

    always_comb begin
        rcNext.ctrl    = ctrlR;
        rcNext.rs1Data = rs1DataR;
        rcNext.rs2Data = rs2DataR;
        rcNext.imm     = immR;
        rcNext.rs1Adr  = irReg.instr.rFormat.rs1;
        rcNext.rs2Adr  = irReg.instr.rFormat.rs2;
        // Bubble behind a stalled load consumer
        if (stall) begin
            rcNext.ctrl.regWrite   = 1'b0;
            rcNext.ctrl.memEn      = 1'b0;
            rcNext.ctrl.memWriteEn = 1'b0;
        end
    end

    hazardUnit u_hazardUnit (
        .rs1AdrR (irReg.instr.rFormat.rs1),
        .rs2AdrR (irReg.instr.rFormat.rs2),
        .rs1AdrC (rcReg.rs1Adr),
        .rs2AdrC (rcReg.rs2Adr),
        .ctrlC   (rcReg.ctrl),
        .ctrlM   (cmReg.ctrl),
        .ctrlW   (mwReg.ctrl),
        .fwdA    (fwdA),
        .fwdB    (fwdB),
        .stall   (stall)
    );

    // C stage
    executeUnit u_executeUnit (
        .rs1Data       (rcReg.rs1Data),
        .rs2Data       (rcReg.rs2Data),
        .imm           (rcReg.imm),
        .ctrl          (rcReg.ctrl),
        .fwdA          (fwdA),
        .fwdB          (fwdB),
        .resultM       (cmReg.computeResult),
        .resultW       (resultW),
        .computeResult (computeResultC),
        .storeData     (storeDataC)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rcReg <= '0;
            cmReg <= '0;
            mwReg <= '0;
        end else begin
            rcReg               <= rcNext;
            cmReg.ctrl          <= rcReg.ctrl;
            cmReg.computeResult <= computeResultC;
            cmReg.storeData     <= storeDataC;
            mwReg.ctrl          <= cmReg.ctrl;
            mwReg.computeResult <= cmReg.computeResult;
            mwReg.memReadData   <= memReadData;
        end
    end

    // M stage drives the data port
    assign dmem.en        = cmReg.ctrl.memEn;
    assign dmem.writeEn   = cmReg.ctrl.memWriteEn;
    assign dmem.adr       = cmReg.computeResult;
    assign dmem.writeData = cmReg.storeData;

    // W stage
    assign resultW = mwReg.ctrl.resultIsMem ? mwReg.memReadData : mwReg.computeResult;

endmodule

// ==== verilog/corePkg.sv ====
// RV32I subset only: ALU ops, LUI, word LW/SW; no branches, jumps, AUIPC or sub-word access
package corePkg;

    // Datapath and register file sizes
    localparam int xlen        = 32;
    localparam int regCount    = 32;
    localparam int regAdrWidth = 5;

    // Major opcodes the core understands
    localparam logic [6:0] opOp    = 7'b0110011;
    localparam logic [6:0] opOpImm = 7'b0010011;
    localparam logic [6:0] opLui   = 7'b0110111;
    localparam logic [6:0] opLoad  = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;

    // Instruction word views
    typedef struct packed {
        logic [6:0]             funct7;
        logic [regAdrWidth-1:0] rs2;
        logic [regAdrWidth-1:0] rs1;
        logic [2:0]             funct3;
        logic [regAdrWidth-1:0] rd;
        logic [6:0]             opcode;
    } rFormatView;

    typedef struct packed {
        logic [11:0]            imm;
        logic [regAdrWidth-1:0] rs1;
        logic [2:0]             funct3;
        logic [regAdrWidth-1:0] rd;
        logic [6:0]             opcode;
    } iFormatView;

    typedef struct packed {
        logic [6:0]             immHi;
        logic [regAdrWidth-1:0] rs2;
        logic [regAdrWidth-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             immLo;
        logic [6:0]             opcode;
    } sFormatView;

    typedef struct packed {
        logic [19:0]            imm;
        logic [regAdrWidth-1:0] rd;
        logic [6:0]             opcode;
    } uFormatView;

    // One 32-bit word, decoded per format
    typedef union packed {
        rFormatView rFormat;
        iFormatView iFormat;
        sFormatView sFormat;
        uFormatView uFormat;
    } instrWord;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor,
        aluSll, aluSrl, aluSra, aluSlt, aluSltu
    } aluOp;

    // Control that follows an instruction from R through W
    typedef struct packed {
        logic                   regWrite;
        logic                   memEn;
        logic                   memWriteEn;
        aluOp                   aluOp;
        logic                   useImm;
        logic                   computeIsImm;
        logic                   resultIsMem;
        logic [regAdrWidth-1:0] rd;
    } ctrlBundle;

    typedef enum logic [1:0] {
        noForward, fromM, fromW
    } fwdSrc;

    // Data port request, driven from M
    typedef struct packed {
        logic            en;
        logic            writeEn;
        logic [xlen-1:0] adr;
        logic [xlen-1:0] writeData;
    } memRequest;

endpackage

// ==== verilog/executeUnit.sv ====
// Combinational C stage; store data always comes from the forwarded rs2, not the immediate
`timescale 1ns/1ps

module executeUnit (
    input  logic [corePkg::xlen-1:0] rs1Data,
    input  logic [corePkg::xlen-1:0] rs2Data,
    input  logic [corePkg::xlen-1:0] imm,
    input  corePkg::ctrlBundle       ctrl,
    input  corePkg::fwdSrc           fwdA,
    input  corePkg::fwdSrc           fwdB,
    input  logic [corePkg::xlen-1:0] resultM,
    input  logic [corePkg::xlen-1:0] resultW,
    output logic [corePkg::xlen-1:0] computeResult,
    output logic [corePkg::xlen-1:0] storeData
);
    import corePkg::*;

    logic [xlen-1:0]         operandA;
    logic [xlen-1:0]         operandB;
    logic [xlen-1:0]         aluResult;
    logic [$clog2(xlen)-1:0] shamt;

    function automatic logic [xlen-1:0] pickSource(fwdSrc src, logic [xlen-1:0] regValue);
        logic [xlen-1:0] value;
        case (src)
            fromM:   value = resultM;
            fromW:   value = resultW;
            default: value = regValue;
        endcase
        return value;
    endfunction

    // Forwarding muxes
    always_comb begin
        operandA  = pickSource(fwdA, rs1Data);
        storeData = pickSource(fwdB, rs2Data);
    end

    // Immediate for OP-IMM, loads and stores
    assign operandB = ctrl.useImm ? imm : storeData;
    assign shamt    = operandB[$clog2(xlen)-1:0];

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  aluResult = operandA + operandB;
            aluSub:  aluResult = operandA - operandB;
            aluAnd:  aluResult = operandA & operandB;
            aluOr:   aluResult = operandA | operandB;
            aluXor:  aluResult = operandA ^ operandB;
            aluSll:  aluResult = operandA << shamt;
            aluSrl:  aluResult = operandA >> shamt;
            aluSra:  aluResult = $unsigned($signed(operandA) >>> shamt);
            aluSlt: begin
                aluResult = {{(xlen-1){1'b0}}, $signed(operandA) < $signed(operandB)};
            end
            aluSltu: begin
                aluResult = {{(xlen-1){1'b0}}, operandA < operandB};
            end
            default: aluResult = '0;
        endcase
    end

    // LUI passes its immediate straight through
    assign computeResult = ctrl.computeIsImm ? imm : aluResult;

endmodule

// ==== verilog/hazardUnit.sv ====
// Forwards from M and W only; a load in M is never forwarded, the load-use stall covers it
`timescale 1ns/1ps

module hazardUnit (
    input  logic [corePkg::regAdrWidth-1:0] rs1AdrR,
    input  logic [corePkg::regAdrWidth-1:0] rs2AdrR,
    input  logic [corePkg::regAdrWidth-1:0] rs1AdrC,
    input  logic [corePkg::regAdrWidth-1:0] rs2AdrC,
    input  corePkg::ctrlBundle              ctrlC,
    input  corePkg::ctrlBundle              ctrlM,
    input  corePkg::ctrlBundle              ctrlW,
    output corePkg::fwdSrc                  fwdA,
    output corePkg::fwdSrc                  fwdB,
    output logic                            stall
);
    import corePkg::*;

    logic loadInC;

    // Youngest producer wins
    function automatic fwdSrc chooseSource(logic [regAdrWidth-1:0] srcAdr,
                                           ctrlBundle m, ctrlBundle w);
        fwdSrc src;
        if (srcAdr != '0 && m.regWrite && m.rd == srcAdr) begin
            src = fromM;
        end else if (srcAdr != '0 && w.regWrite && w.rd == srcAdr) begin
            src = fromW;
        end else begin
            src = noForward;
        end
        return src;
    endfunction

    assign fwdA = chooseSource(rs1AdrC, ctrlM, ctrlW);
    assign fwdB = chooseSource(rs2AdrC, ctrlM, ctrlW);

    // Load data only exists in W, so the consumer waits one cycle
    assign loadInC = ctrlC.regWrite && ctrlC.resultIsMem && (ctrlC.rd != '0);
    assign stall   = loadInC && (ctrlC.rd == rs1AdrR || ctrlC.rd == rs2AdrR);

endmodule

// ==== verilog/instrDecoder.sv ====
// Decodes only OP, OP-IMM, LUI, LW and SW; any other opcode becomes a no-op bundle
`timescale 1ns/1ps

module instrDecoder (
    input  corePkg::instrWord        instr,
    output corePkg::ctrlBundle       ctrl,
    output logic [corePkg::xlen-1:0] imm
);
    import corePkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       altBit;
    aluOp       fieldOp;

    assign opcode = instr.rFormat.opcode;
    assign funct3 = instr.rFormat.funct3;

    // Instruction bit 30 picks sub and sra
    assign altBit = instr.rFormat.funct7[5];

    // ALU operation from funct3, shared by OP and OP-IMM
    always_comb begin
        case (funct3)
            3'b000:  fieldOp = (opcode == opOp && altBit) ? aluSub : aluAdd;
            3'b001:  fieldOp = aluSll;
            3'b010:  fieldOp = aluSlt;
            3'b011:  fieldOp = aluSltu;
            3'b100:  fieldOp = aluXor;
            3'b101:  fieldOp = altBit ? aluSra : aluSrl;
            3'b110:  fieldOp = aluOr;
            default: fieldOp = aluAnd;
        endcase
    end

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = aluAdd;
        ctrl.rd    = instr.rFormat.rd;
        imm        = '0;

        case (opcode)
            opOp: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = fieldOp;
            end
            opOpImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.useImm   = 1'b1;
                ctrl.aluOp    = fieldOp;
                // Shift amount sits in the low immediate bits
                imm = {{(xlen-12){instr.iFormat.imm[11]}}, instr.iFormat.imm};
            end
            opLui: begin
                ctrl.regWrite     = 1'b1;
                ctrl.computeIsImm = 1'b1;
                imm = {instr.uFormat.imm, 12'b0};
            end
            opLoad: begin
                ctrl.regWrite    = 1'b1;
                ctrl.memEn       = 1'b1;
                ctrl.useImm      = 1'b1;
                ctrl.resultIsMem = 1'b1;
                imm = {{(xlen-12){instr.iFormat.imm[11]}}, instr.iFormat.imm};
            end
            opStore: begin
                ctrl.memEn      = 1'b1;
                ctrl.memWriteEn = 1'b1;
                ctrl.useImm     = 1'b1;
                // Rd field holds immediate bits here
                ctrl.rd = '0;
                imm = {{(xlen-12){instr.sFormat.immHi[6]}},
                       instr.sFormat.immHi, instr.sFormat.immLo};
            end
            default: begin
                ctrl.rd = '0;
            end
        endcase
    end

endmodule

// ==== verilog/registerFile.sv ====
// Two read ports, one write port; x0 reads zero and a same-cycle write bypasses to the reads
`timescale 1ns/1ps

module registerFile (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            writeEn,
    input  logic [corePkg::regAdrWidth-1:0] rs1Adr,
    input  logic [corePkg::regAdrWidth-1:0] rs2Adr,
    input  logic [corePkg::regAdrWidth-1:0] rdAdr,
    input  logic [corePkg::xlen-1:0]        rdData,
    output logic [corePkg::xlen-1:0]        rs1Data,
    output logic [corePkg::xlen-1:0]        rs2Data
);
    import corePkg::*;

    // No storage behind x0
    logic [xlen-1:0] regs [1:regCount-1];

    function automatic logic [xlen-1:0] readPort(logic [regAdrWidth-1:0] adr);
        logic [xlen-1:0] value;
        if (adr == '0) begin
            value = '0;
        end else if (writeEn && rdAdr == adr) begin
            value = rdData;
        end else begin
            value = regs[adr];
        end
        return value;
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && rdAdr != '0) begin
            regs[rdAdr] <= rdData;
        end
    end

    always_comb begin
        rs1Data = readPort(rs1Adr);
        rs2Data = readPort(rs2Adr);
    end

endmodule
